//--- dv/lsu_cases.txt
# op size sext addr wdata expected_rdata expected_err
# size is one-hot (1 byte, 2 halfword, 4 word) and every value is hex
st 4 0 00000000 01020304 00000000 0
st 4 0 00000100 deadbeef 00000000 0
ld 4 0 00000100 00000000 deadbeef 0
st 4 0 00000104 11223344 00000000 0
st 1 0 00000105 000000aa 00000000 0
st 2 0 00000106 0000bbcc 00000000 0
ld 4 0 00000104 00000000 bbccaa44 0
st 1 0 00000104 000000ee 00000000 0
ld 4 0 00000104 00000000 bbccaaee 0
st 4 0 00000108 8a7bf40c 00000000 0
ld 1 1 00000108 00000000 0000000c 0
ld 1 1 00000109 00000000 fffffff4 0
ld 1 0 00000109 00000000 000000f4 0
ld 1 0 0000010a 00000000 0000007b 0
ld 1 1 0000010b 00000000 ffffff8a 0
ld 1 0 0000010b 00000000 0000008a 0
ld 2 1 00000108 00000000 fffff40c 0
ld 2 0 00000108 00000000 0000f40c 0
ld 2 1 0000010a 00000000 ffff8a7b 0
ld 2 0 0000010a 00000000 00008a7b 0
st 2 0 00000101 0000ffff 00000000 0
st 4 0 00000102 00000000 00000000 0
ld 4 0 00000100 00000000 deadbeef 0
ld 4 0 00000102 00000000 deadbeef 0
ld 2 1 00000101 00000000 00000000 0
ld 2 0 00000103 00000000 00000000 0
st 4 0 00000400 cafef00d 00000000 1
st 1 0 12345679 000000ff 00000000 1
ld 4 0 00000400 00000000 00000000 1
ld 1 1 00000ffc 00000000 00000000 1
ld 4 0 00000000 00000000 01020304 0

//--- dv/lsu_tb.sv
module lsu_tb;
    import lsu_pkg::*;

    logic  clk;
    logic  rst;
    logic  mem_valid;
    logic  mem_ren;
    logic  mem_wen;
    addr_t mem_addr;
    size_t mem_size;
    logic  mem_sext;
    data_t mem_wdata;
    data_t mem_rdata;
    logic  mem_rvalid;
    logic  mem_wcomplete;
    logic  mem_err;
    logic  mem_access_start;

    // one entry per case line
    logic  c_store[$];
    size_t c_size[$];
    logic  c_sext[$];
    addr_t c_addr[$];
    data_t c_wdata[$];
    data_t c_rdata[$];
    logic  c_err[$];

    logic [31:0] lfsr;
    int          cycles = 0;
    int          cycle_limit = 0;

    lsu_subsys_top DUT (
        .clk              (clk),
        .rst              (rst),
        .mem_valid        (mem_valid),
        .mem_ren          (mem_ren),
        .mem_wen          (mem_wen),
        .mem_addr         (mem_addr),
        .mem_size         (mem_size),
        .mem_sext         (mem_sext),
        .mem_wdata        (mem_wdata),
        .mem_rdata        (mem_rdata),
        .mem_rvalid       (mem_rvalid),
        .mem_wcomplete    (mem_wcomplete),
        .mem_err          (mem_err),
        .mem_access_start (mem_access_start)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            stop_run($sformatf("timeout after %0d cycles without the expected completion",
                               cycles));
        end
    end

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("error at time %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_run($sformatf("error at time %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic expect_no_pulses(input string what);
        check_flag(mem_access_start, 1'b0, {what, " start pulse"});
        check_flag(mem_rvalid, 1'b0, {what, " load completion"});
        check_flag(mem_wcomplete, 1'b0, {what, " store completion"});
    endtask

    // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [15:0] op;
        size_t       size;
        logic        sext;
        addr_t       addr;
        data_t       wdata;
        data_t       rdata;
        logic        err;
        fd = $fopen("dv/lsu_cases.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open the case file dv/lsu_cases.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) != "#") begin // skip column notes
                n = $sscanf(line, "%s %h %h %h %h %h %h",
                            op, size, sext, addr, wdata, rdata, err);
                if (n == 7) begin
                    if (op != "st" && op != "ld") begin
                        stop_run({"unknown operation in case line: ", line});
                    end
                    c_store.push_back(op == "st");
                    c_size.push_back(size);
                    c_sext.push_back(sext);
                    c_addr.push_back(addr);
                    c_wdata.push_back(wdata);
                    c_rdata.push_back(rdata);
                    c_err.push_back(err);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int i);
        int    starts;
        logic  done;
        string tag;
        starts = 0;
        done   = 1'b0;
        tag    = $sformatf("case %0d", i);
        @(posedge clk);
        #10;
        mem_valid = 1'b1;
        mem_wen   = c_store[i];
        mem_ren   = !c_store[i];
        mem_addr  = c_addr[i];
        mem_size  = c_size[i];
        mem_sext  = c_sext[i];
        mem_wdata = c_wdata[i];
        // level stays up until the completion pulse
        while (!done) begin
            @(negedge clk);
            starts = starts + int'(mem_access_start);
            if (c_store[i]) begin
                check_flag(mem_rvalid, 1'b0, {tag, " load completion during a store"});
                done = (mem_wcomplete === 1'b1);
            end else begin
                check_flag(mem_wcomplete, 1'b0, {tag, " store completion during a load"});
                done = (mem_rvalid === 1'b1);
            end
        end
        check_flag(logic'(starts == 1), 1'b1, {tag, " exactly one start pulse"});
        check_flag(mem_err, c_err[i], {tag, " error flag"});
        if (!c_store[i]) begin
            check_data(mem_rdata, c_rdata[i], {tag, " load data"});
        end
        // master is idle again while the level is still held
        @(negedge clk);
        expect_no_pulses({tag, " held level"});
        @(posedge clk);
        #10;
        mem_valid = 1'b0;
        mem_wen   = 1'b0;
        mem_ren   = 1'b0;
    endtask

    task automatic idle_gap();
        logic [1:0] gap;
        gap[0] = lfsr[0];
        lfsr   = lfsr_next(lfsr);
        gap[1] = lfsr[0];
        lfsr   = lfsr_next(lfsr);
        repeat (int'(gap) + 1) begin
            @(negedge clk);
            expect_no_pulses("idle");
        end
    endtask

    initial begin
        rst       = 1'b1;
        mem_valid = 1'b0;
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        mem_addr  = '0;
        mem_size  = '0;
        mem_sext  = 1'b0;
        mem_wdata = '0;
        lfsr      = 32'hd76f6c74;
        load_cases();
        if (c_store.size() == 0) begin
            stop_run("the case file holds no cases");
        end
        cycle_limit = c_store.size() * 40 + 100;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            expect_no_pulses("after reset");
        end
        for (int i = 0; i < c_store.size(); i++) begin
            run_case(i);
            idle_gap();
        end
        $display("All checks passed");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_align.sv
verilog/lsu_axi_master.sv
verilog/lsu_sram_slave.sv
verilog/lsu_subsys_top.sv
dv/lsu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the LSU testbench with Verilator and runs it from the project root
# the exit status is nonzero when the build fails or the testbench stops with $fatal

cd "$(dirname "$0")" &&
verilator --binary --timing -f filelist.f --top-module lsu_tb -Mdir obj_dir &&
./obj_dir/Vlsu_tb ||
{
    echo "simulation did not pass"
    exit 1
}

//--- verilog/lsu_align.sv
`include "lsu_config.svh"

module lsu_align (
    input  lsu_pkg::addr_t st_addr,
    input  lsu_pkg::size_t st_size,
    input  lsu_pkg::data_t st_data,
    output lsu_pkg::data_t st_lane_data,
    output lsu_pkg::strb_t st_strb,
    input  logic [1:0]     ld_offset,
    input  lsu_pkg::size_t ld_size,
    input  logic           ld_sext,
    input  lsu_pkg::data_t ld_raw,
    output lsu_pkg::data_t ld_data
);
    import lsu_pkg::*;

    logic [1:0]  st_offset;
    data_t       ld_shifted;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // store side

    assign st_offset    = st_addr[1:0];
    assign st_lane_data = st_data << {st_offset, 3'b000};

    always_comb begin
        st_strb = '0;
        if (st_size[2]) begin
            if (st_offset == 2'b00) begin
                st_strb = '1;
            end
        end else if (st_size[1]) begin
            if (!st_offset[0]) begin
                st_strb = strb_t'(3) << st_offset; // lanes 0-1 or 2-3
            end
        end else if (st_size[0]) begin
            st_strb = strb_t'(1) << st_offset;
        end
    end

    // load side, bring the addressed lane down to bit 0
    assign ld_shifted = ld_raw >> {ld_offset, 3'b000};
    assign ld_byte    = ld_shifted[7:0];
    assign ld_half    = ld_shifted[15:0];

    always_comb begin
        ld_data = '0;
        if (ld_size[2]) begin
            ld_data = ld_raw; // low address bits ignored
        end else if (ld_size[1]) begin
            // odd halfword offset leaves zero
            if (!ld_offset[0]) begin
                if (ld_sext) begin
                    ld_data = {{(`LSU_DATA_WIDTH-16){ld_half[15]}}, ld_half};
                end else begin
                    ld_data = {{(`LSU_DATA_WIDTH-16){1'b0}}, ld_half};
                end
            end
        end else if (ld_size[0]) begin
            if (ld_sext) begin
                ld_data = {{(`LSU_DATA_WIDTH-8){ld_byte[7]}}, ld_byte};
            end else begin
                ld_data = {{(`LSU_DATA_WIDTH-8){1'b0}}, ld_byte};
            end
        end
    end

endmodule

//--- verilog/lsu_axi_master.sv
`include "lsu_config.svh"

module lsu_axi_master (
    input  logic           clk,
    input  logic           rst,
    input  logic           mem_valid,
    input  logic           mem_ren,
    input  logic           mem_wen,
    input  lsu_pkg::addr_t mem_addr,
    input  lsu_pkg::size_t mem_size,
    input  logic           mem_sext,
    input  lsu_pkg::data_t st_lane_data,
    input  lsu_pkg::strb_t st_strb,
    output logic [1:0]     ld_offset,
    output lsu_pkg::size_t ld_size,
    output logic           ld_sext,
    output lsu_pkg::data_t ld_raw,
    output logic           mem_rvalid,
    output logic           mem_wcomplete,
    output logic           mem_err,
    output logic           mem_access_start,
    output logic           awvalid,
    input  logic           awready,
    output lsu_pkg::addr_t awaddr,
    output logic           wvalid,
    input  logic           wready,
    output lsu_pkg::data_t wdata,
    output lsu_pkg::strb_t wstrb,
    input  logic           bvalid,
    output logic           bready,
    input  lsu_pkg::resp_t bresp,
    output logic           arvalid,
    input  logic           arready,
    output lsu_pkg::addr_t araddr,
    input  logic           rvalid,
    output logic           rready,
    input  lsu_pkg::data_t rdata,
    input  lsu_pkg::resp_t rresp
);
    import lsu_pkg::*;

    master_state_t state;
    master_state_t state_next;

    logic  wr_req;
    logic  rd_req;
    logic  wr_req_q;
    logic  rd_req_q;
    logic  wr_start;
    logic  rd_start;

    addr_t addr_q;
    size_t size_q;
    logic  sext_q;
    data_t wdata_q;
    strb_t strb_q;

    logic  aw_fire;
    logic  w_fire;
    logic  b_fire;
    logic  ar_fire;
    logic  r_fire;

    assign wr_req = mem_valid & mem_wen;
    assign rd_req = mem_valid & mem_ren;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_req_q <= 1'b0;
            rd_req_q <= 1'b0;
        end else begin
            wr_req_q <= wr_req;
            rd_req_q <= rd_req;
        end
    end

    // edges seen while busy are dropped
    assign wr_start = wr_req & ~wr_req_q & (state == ms_idle);
    assign rd_start = rd_req & ~rd_req_q & (state == ms_idle) & ~wr_start; // store wins a tie
    assign mem_access_start = wr_start | rd_start;

    always_ff @(posedge clk) begin
        if (mem_access_start) begin
            addr_q  <= mem_addr;
            size_q  <= mem_size;
            sext_q  <= mem_sext;
            wdata_q <= st_lane_data;
            strb_q  <= st_strb;
        end
    end

    assign aw_fire = awvalid & awready;
    assign w_fire  = wvalid & wready;
    assign b_fire  = bvalid & bready;
    assign ar_fire = arvalid & arready;
    assign r_fire  = rvalid & rready;

    always_comb begin
        state_next = state;
        case (state)
            ms_idle: begin
                if (wr_start) begin
                    state_next = ms_aw;
                end else if (rd_start) begin
                    state_next = ms_ar;
                end
            end
            ms_aw:   if (aw_fire) state_next = ms_w;
            ms_w:    if (w_fire)  state_next = ms_b;
            ms_b:    if (b_fire)  state_next = ms_idle;
            ms_ar:   if (ar_fire) state_next = ms_r;
            ms_r:    if (r_fire)  state_next = ms_idle;
            default: state_next = ms_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ms_idle;
        end else begin
            state <= state_next;
        end
    end

    assign awvalid = (state == ms_aw);
    assign awaddr  = addr_q;
    assign wvalid  = (state == ms_w);
    assign wdata   = wdata_q;
    assign wstrb   = strb_q;
    assign bready  = (state == ms_w) | (state == ms_b); // up early, never stalls b
    assign arvalid = (state == ms_ar);
    assign araddr  = addr_q;
    assign rready  = (state == ms_ar) | (state == ms_r);

    assign mem_wcomplete = b_fire;
    assign mem_rvalid    = r_fire;
    assign mem_err       = (b_fire & (bresp != resp_okay)) | (r_fire & (rresp != resp_okay));

    // load extension works from the held request
    assign ld_offset = addr_q[1:0];
    assign ld_size   = size_q;
    assign ld_sext   = sext_q;
    assign ld_raw    = r_fire ? rdata : {`LSU_DATA_WIDTH{1'b0}};

endmodule

//--- verilog/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// register width, also used as the byte address width
`define LSU_DATA_WIDTH 32

// sram depth in 32-bit words
// byte addresses from 4 * LSU_MEM_WORDS upward get SLVERR
`define LSU_MEM_WORDS 256

// idle cycles each ready stays low after its valid rises
`define LSU_SRAM_WAIT 2

`endif

//--- verilog/lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

    typedef logic [`LSU_DATA_WIDTH-1:0]   addr_t;
    typedef logic [`LSU_DATA_WIDTH-1:0]   data_t;
    typedef logic [`LSU_DATA_WIDTH/8-1:0] strb_t;

    // one-hot: bit 0 byte, bit 1 halfword, bit 2 word
    typedef logic [2:0] size_t;

    typedef logic [1:0] resp_t;

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // bus master sequencing, store runs aw/w/b and load runs ar/r
    typedef enum logic [2:0] {
        ms_idle,
        ms_aw,
        ms_w,
        ms_b,
        ms_ar,
        ms_r
    } master_state_t;

endpackage

//--- verilog/lsu_sram_slave.sv
`include "lsu_config.svh"

module lsu_sram_slave (
    input  logic           clk,
    input  logic           rst,
    input  logic           awvalid,
    output logic           awready,
    input  lsu_pkg::addr_t awaddr,
    input  logic           wvalid,
    output logic           wready,
    input  lsu_pkg::data_t wdata,
    input  lsu_pkg::strb_t wstrb,
    output logic           bvalid,
    input  logic           bready,
    output lsu_pkg::resp_t bresp,
    input  logic           arvalid,
    output logic           arready,
    input  lsu_pkg::addr_t araddr,
    output logic           rvalid,
    input  logic           rready,
    output lsu_pkg::data_t rdata,
    output lsu_pkg::resp_t rresp
);
    import lsu_pkg::*;

    localparam int IDX_W  = $clog2(`LSU_MEM_WORDS);
    localparam int CNT_W  = $clog2(`LSU_SRAM_WAIT + 2);
    localparam int STRB_W = `LSU_DATA_WIDTH / 8;

    data_t            mem [`LSU_MEM_WORDS];
    logic [CNT_W-1:0] wait_cnt;
    logic             wait_done;
    logic             req_pending;
    addr_t            waddr_q;
    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] ridx;
    logic             w_in_range;
    logic             r_in_range;
    logic             aw_fire;
    logic             w_fire;
    logic             ar_fire;

    // only one request channel is active at a time, so one counter paces all three
    assign req_pending = awvalid | wvalid | arvalid;
    assign wait_done   = (wait_cnt == CNT_W'(`LSU_SRAM_WAIT));

    assign awready = awvalid & wait_done;
    assign wready  = wvalid & wait_done;
    assign arready = arvalid & wait_done;

    assign aw_fire = awvalid & awready;
    assign w_fire  = wvalid & wready;
    assign ar_fire = arvalid & arready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (aw_fire | w_fire | ar_fire) begin
            wait_cnt <= '0;
        end else if (req_pending & ~wait_done) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    assign widx       = waddr_q[IDX_W+1:2];
    assign ridx       = araddr[IDX_W+1:2];
    assign w_in_range = (waddr_q >> 2) < addr_t'(`LSU_MEM_WORDS);
    assign r_in_range = (araddr >> 2) < addr_t'(`LSU_MEM_WORDS);

    always_ff @(posedge clk) begin
        if (aw_fire) begin
            waddr_q <= awaddr;
        end
    end

    // byte-strobed write, dropped when out of range
    always_ff @(posedge clk) begin
        if (w_fire && w_in_range) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wstrb[i]) begin
                    mem[widx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (w_fire) begin
            bresp <= w_in_range ? resp_okay : resp_slverr;
        end
        if (ar_fire) begin
            rdata <= r_in_range ? mem[ridx] : '0;
            rresp <= r_in_range ? resp_okay : resp_slverr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (w_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/lsu_subsys_top.sv
`include "lsu_config.svh"

module lsu_subsys_top (
    input  logic           clk,
    input  logic           rst,
    input  logic           mem_valid,
    input  logic           mem_ren,
    input  logic           mem_wen,
    input  lsu_pkg::addr_t mem_addr,
    input  lsu_pkg::size_t mem_size,
    input  logic           mem_sext,
    input  lsu_pkg::data_t mem_wdata,
    output lsu_pkg::data_t mem_rdata,
    output logic           mem_rvalid,
    output logic           mem_wcomplete,
    output logic           mem_err,
    output logic           mem_access_start
);
    import lsu_pkg::*;

    data_t      st_lane_data;
    strb_t      st_strb;
    logic [1:0] ld_offset;
    size_t      ld_size;
    logic       ld_sext;
    data_t      ld_raw;

    // bus between master and sram
    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    logic  wvalid;
    logic  wready;
    data_t wdata;
    strb_t wstrb;
    logic  bvalid;
    logic  bready;
    resp_t bresp;
    logic  arvalid;
    logic  arready;
    addr_t araddr;
    logic  rvalid;
    logic  rready;
    data_t rdata;
    resp_t rresp;

    lsu_align u_align (
        .st_addr      (mem_addr),
        .st_size      (mem_size),
        .st_data      (mem_wdata),
        .st_lane_data (st_lane_data),
        .st_strb      (st_strb),
        .ld_offset    (ld_offset),
        .ld_size      (ld_size),
        .ld_sext      (ld_sext),
        .ld_raw       (ld_raw),
        .ld_data      (mem_rdata)
    );

    lsu_axi_master u_master (
        .clk              (clk),
        .rst              (rst),
        .mem_valid        (mem_valid),
        .mem_ren          (mem_ren),
        .mem_wen          (mem_wen),
        .mem_addr         (mem_addr),
        .mem_size         (mem_size),
        .mem_sext         (mem_sext),
        .st_lane_data     (st_lane_data),
        .st_strb          (st_strb),
        .ld_offset        (ld_offset),
        .ld_size          (ld_size),
        .ld_sext          (ld_sext),
        .ld_raw           (ld_raw),
        .mem_rvalid       (mem_rvalid),
        .mem_wcomplete    (mem_wcomplete),
        .mem_err          (mem_err),
        .mem_access_start (mem_access_start),
        .awvalid          (awvalid),
        .awready          (awready),
        .awaddr           (awaddr),
        .wvalid           (wvalid),
        .wready           (wready),
        .wdata            (wdata),
        .wstrb            (wstrb),
        .bvalid           (bvalid),
        .bready           (bready),
        .bresp            (bresp),
        .arvalid          (arvalid),
        .arready          (arready),
        .araddr           (araddr),
        .rvalid           (rvalid),
        .rready           (rready),
        .rdata            (rdata),
        .rresp            (rresp)
    );

    lsu_sram_slave u_sram (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

endmodule
